//--- verilog/fabric_config.svh
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// bits per lane value
`define FABRIC_DATA_WIDTH 16

// input lanes, mux tree is built for eight
`define FABRIC_LANES 8

// output ports, power of two
`define FABRIC_PORTS 2

// accumulate length field
`define FABRIC_LEN_WIDTH 4

`endif

//--- verilog/fabric_types_pkg.sv
`default_nettype none

`include "fabric_config.svh"

package fabric_types_pkg;

	// single lane value
	typedef logic [`FABRIC_DATA_WIDTH-1:0] lane_data_t;

	// lane k sits at slice k
	typedef logic [`FABRIC_LANES*`FABRIC_DATA_WIDTH-1:0] lane_bus_t;

	// port p sits at slice p
	typedef logic [`FABRIC_PORTS*`FABRIC_DATA_WIDTH-1:0] port_bus_t;

	typedef logic [`FABRIC_LANES-1:0] lane_valid_t;
	typedef logic [`FABRIC_PORTS-1:0] port_valid_t;

endpackage

`default_nettype wire

//--- verilog/fabric_cmd_pkg.sv
`default_nettype none

`include "fabric_config.svh"

package fabric_cmd_pkg;

	typedef enum logic
	{
		MODE_PASS  = 1'b0,   // forward every beat
		MODE_ACCUM = 1'b1    // one sum per programmed count
	} port_mode_t;

	// source lane number
	typedef logic [$clog2(`FABRIC_LANES)-1:0] lane_idx_t;

	// valid beats per sum, zero acts as one
	typedef logic [`FABRIC_LEN_WIDTH-1:0] acc_len_t;

	// bit lane*PORTS+port set when that port takes that lane
	typedef logic [`FABRIC_LANES*`FABRIC_PORTS-1:0] route_cmd_t;

	// one mode bit per port, port p at bit p
	typedef logic [`FABRIC_PORTS-1:0] port_mode_vec_t;

	// one length per port, port p at slice p
	typedef logic [`FABRIC_PORTS*`FABRIC_LEN_WIDTH-1:0] port_len_vec_t;

endpackage

`default_nettype wire

//--- verilog/route_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_config.svh"

module route_ctrl
	import fabric_types_pkg::*, fabric_cmd_pkg::*;
(
	input  logic                             CLK,
	input  logic                             i_reset,

	input  logic                             i_run,

	// route table write
	input  logic                             i_cfg_we,
	input  logic [$clog2(`FABRIC_PORTS)-1:0] i_cfg_port,
	input  lane_idx_t                        i_cfg_src,
	input  logic                             i_cfg_on,
	input  port_mode_t                       i_cfg_mode,
	input  acc_len_t                         i_cfg_len,

	// to mux tree
	output route_cmd_t                       o_cmd,
	output logic                             o_mux_en,

	// to the accumulators
	output port_mode_vec_t                   o_mode,
	output port_len_vec_t                    o_len,
	output port_valid_t                      o_clear
);

	localparam int LW = `FABRIC_LEN_WIDTH;

	lane_idx_t      src_q [`FABRIC_PORTS];
	port_valid_t    on_q;
	port_mode_vec_t mode_q;
	port_len_vec_t  len_q;
	port_valid_t    clear_q;
	port_valid_t    port_we;

	// decode write strobe per port
	always_comb
	begin
		port_we = '0;
		if (i_cfg_we)
			port_we[i_cfg_port] = 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (i_reset)
		begin
			on_q    <= '0;
			mode_q  <= '0;      // every port back to MODE_PASS
			clear_q <= '0;
		end
		else
		begin
			clear_q <= port_we; // flush pulse, one cycle after the write
			for (int p = 0; p < `FABRIC_PORTS; p++)
			begin
				if (port_we[p])
				begin
					on_q[p]   <= i_cfg_on;
					mode_q[p] <= i_cfg_mode;
				end
			end
		end
	end

	// source lane and sum length of each entry
	always_ff @(posedge CLK)
	begin
		for (int p = 0; p < `FABRIC_PORTS; p++)
		begin
			if (port_we[p])
			begin
				src_q[p]          <= i_cfg_src;
				len_q[p*LW +: LW] <= i_cfg_len;
			end
		end
	end

	// lane-major one-hot expansion, ports that are off stay all zero
	always_comb
	begin
		o_cmd = '0;
		for (int p = 0; p < `FABRIC_PORTS; p++)
		begin
			if (on_q[p])
				o_cmd[int'(src_q[p]) * `FABRIC_PORTS + p] = 1'b1;
		end
	end

	assign o_mux_en = i_run;
	assign o_mode   = mode_q;
	assign o_len    = len_q;
	assign o_clear  = clear_q;

endmodule

`default_nettype wire

//--- verilog/mux_tree_8_1_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_config.svh"

module mux_tree_8_1_seq
	import fabric_types_pkg::*, fabric_cmd_pkg::*;
#(
	parameter int DATA_WIDTH      = `FABRIC_DATA_WIDTH,
	parameter int NUM_OUTPUT_DATA = `FABRIC_PORTS   // power of two
)(
	input  logic             CLK,
	input  logic             i_reset,

	input  logic             i_en,
	input  lane_valid_t      i_valid,
	input  lane_bus_t        i_data_bus,
	input  route_cmd_t       i_cmd,        // one-hot, lane-major

	output wire port_valid_t o_valid,
	output wire port_bus_t   o_data_bus
);

	localparam int NUM_INPUT_DATA = 8;

	genvar i;
	generate
		for (i = 0; i < NUM_OUTPUT_DATA; i++)
		begin : g_out
			logic [NUM_INPUT_DATA-1:0] sel;
			logic [2:0]                lane;
			logic                      hit;
			logic                      valid_q;
			logic [DATA_WIDTH-1:0]     data_q;

			// gather this output's bit from every lane group
			always_comb
			begin
				for (int k = 0; k < NUM_INPUT_DATA; k++)
					sel[k] = i_cmd[k*NUM_OUTPUT_DATA + i];
			end

			always_comb
			begin
				hit  = 1'b1;
				lane = 3'd0;
				case (sel)
					8'b00000001: lane = 3'd0;
					8'b00000010: lane = 3'd1;
					8'b00000100: lane = 3'd2;
					8'b00001000: lane = 3'd3;
					8'b00010000: lane = 3'd4;
					8'b00100000: lane = 3'd5;
					8'b01000000: lane = 3'd6;
					8'b10000000: lane = 3'd7;
					default:     hit  = 1'b0;   // nothing or several selected
				endcase
			end

			always_ff @(posedge CLK)
			begin
				if (i_reset || !i_en || !hit || !i_valid[lane])
				begin
					valid_q <= 1'b0;
					data_q  <= '0;
				end
				else
				begin
					valid_q <= 1'b1;
					data_q  <= i_data_bus[lane*DATA_WIDTH +: DATA_WIDTH];
				end
			end

			assign o_valid[i]                             = valid_q;
			assign o_data_bus[i*DATA_WIDTH +: DATA_WIDTH] = data_q;
		end
	endgenerate

endmodule

`default_nettype wire

//--- verilog/port_accum.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_config.svh"

module port_accum
	import fabric_types_pkg::*, fabric_cmd_pkg::*;
(
	input  logic       CLK,
	input  logic       i_reset,

	input  logic       i_clear,   // drop partial sum and beat in flight
	input  port_mode_t i_mode,
	input  acc_len_t   i_len,

	input  logic       i_valid,
	input  lane_data_t i_data,

	output logic       o_valid,
	output lane_data_t o_data
);

	acc_len_t   len_eff;
	acc_len_t   cnt_q;
	lane_data_t sum_q;
	lane_data_t sum_next;
	logic       last_beat;

	assign len_eff   = (i_len == '0) ? acc_len_t'(1) : i_len;
	assign sum_next  = sum_q + i_data;   // wraps at data width
	assign last_beat = (cnt_q == len_eff - acc_len_t'(1));

	always_ff @(posedge CLK)
	begin
		if (i_reset || i_clear)
		begin
			sum_q   <= '0;
			cnt_q   <= '0;
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else if (i_mode == MODE_PASS)
		begin
			sum_q   <= '0;
			cnt_q   <= '0;
			o_valid <= i_valid;
			o_data  <= i_data;
		end
		else
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
			if (i_valid)
			begin
				if (last_beat)
				begin
					// total includes this beat, restart from zero
					o_valid <= 1'b1;
					o_data  <= sum_next;
					sum_q   <= '0;
					cnt_q   <= '0;
				end
				else
				begin
					sum_q <= sum_next;
					cnt_q <= cnt_q + acc_len_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/lane_collector_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_config.svh"

module lane_collector_top
	import fabric_types_pkg::*, fabric_cmd_pkg::*;
(
	input  logic                             CLK,
	input  logic                             i_reset,

	input  logic                             i_run,
	input  lane_valid_t                      i_lane_valid,
	input  lane_bus_t                        i_lane_data,

	input  logic                             i_cfg_we,
	input  logic [$clog2(`FABRIC_PORTS)-1:0] i_cfg_port,
	input  lane_idx_t                        i_cfg_src,
	input  logic                             i_cfg_on,
	input  port_mode_t                       i_cfg_mode,
	input  acc_len_t                         i_cfg_len,

	output wire port_valid_t                 o_port_valid,
	output wire port_bus_t                   o_port_data
);

	localparam int DW = `FABRIC_DATA_WIDTH;
	localparam int LW = `FABRIC_LEN_WIDTH;

	wire route_cmd_t     cmd;
	wire                 mux_en;
	wire port_mode_vec_t mode;
	wire port_len_vec_t  len;
	wire port_valid_t    clear;
	wire port_valid_t    mux_valid;
	wire port_bus_t      mux_data;

	route_ctrl u_route_ctrl (
		.CLK        (CLK),
		.i_reset    (i_reset),
		.i_run      (i_run),
		.i_cfg_we   (i_cfg_we),
		.i_cfg_port (i_cfg_port),
		.i_cfg_src  (i_cfg_src),
		.i_cfg_on   (i_cfg_on),
		.i_cfg_mode (i_cfg_mode),
		.i_cfg_len  (i_cfg_len),
		.o_cmd      (cmd),
		.o_mux_en   (mux_en),
		.o_mode     (mode),
		.o_len      (len),
		.o_clear    (clear)
	);

	mux_tree_8_1_seq #(
		.DATA_WIDTH      (DW),
		.NUM_OUTPUT_DATA (`FABRIC_PORTS)
	) u_mux_tree (
		.CLK        (CLK),
		.i_reset    (i_reset),
		.i_en       (mux_en),
		.i_valid    (i_lane_valid),
		.i_data_bus (i_lane_data),
		.i_cmd      (cmd),
		.o_valid    (mux_valid),
		.o_data_bus (mux_data)
	);

	// one pass/sum stage per port
	genvar p;
	generate
		for (p = 0; p < `FABRIC_PORTS; p++)
		begin : g_port
			port_accum u_accum (
				.CLK     (CLK),
				.i_reset (i_reset),
				.i_clear (clear[p]),
				.i_mode  (port_mode_t'(mode[p])),
				.i_len   (len[p*LW +: LW]),
				.i_valid (mux_valid[p]),
				.i_data  (mux_data[p*DW +: DW]),
				.o_valid (o_port_valid[p]),
				.o_data  (o_port_data[p*DW +: DW])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- dv/lane_collector_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fabric_config.svh"

module lane_collector_tb
	import fabric_types_pkg::*, fabric_cmd_pkg::*;
;

	localparam int DW            = `FABRIC_DATA_WIDTH;
	localparam int NP            = `FABRIC_PORTS;
	localparam int RESET_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 8;

	typedef struct packed {
		logic                     is_cfg;
		logic [$clog2(NP)-1:0]    port;
		lane_idx_t                src;
		logic                     on;
		port_mode_t               mode;
		acc_len_t                 len;
		logic                     run;
		lane_valid_t              valid;
		lane_bus_t                data;
		port_valid_t              exp_valid;   // filled by the model
		port_bus_t                exp_data;
	} row_t;

	logic                  CLK;
	logic                  i_reset;
	logic                  i_run;
	lane_valid_t           i_lane_valid;
	lane_bus_t             i_lane_data;
	logic                  i_cfg_we;
	logic [$clog2(NP)-1:0] i_cfg_port;
	lane_idx_t             i_cfg_src;
	logic                  i_cfg_on;
	port_mode_t            i_cfg_mode;
	acc_len_t              i_cfg_len;
	port_valid_t           o_port_valid;
	port_bus_t             o_port_data;

	integer seed;
	row_t   rows [$];
	row_t   pend_q [$];   // expected outputs, two cycles deep

	lane_collector_top DUT (
		.CLK          (CLK),
		.i_reset      (i_reset),
		.i_run        (i_run),
		.i_lane_valid (i_lane_valid),
		.i_lane_data  (i_lane_data),
		.i_cfg_we     (i_cfg_we),
		.i_cfg_port   (i_cfg_port),
		.i_cfg_src    (i_cfg_src),
		.i_cfg_on     (i_cfg_on),
		.i_cfg_mode   (i_cfg_mode),
		.i_cfg_len    (i_cfg_len),
		.o_port_valid (o_port_valid),
		.o_port_data  (o_port_data)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial
	begin
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		i_reset = 1'b0;
	end

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_outputs(input row_t exp);
		check_value("o_port_valid", 32'(o_port_valid), 32'(exp.exp_valid));
		for (int p = 0; p < NP; p++)
			check_value($sformatf("o_port_data[%0d]", p), 32'(o_port_data[p*DW +: DW]),
				32'(exp.exp_data[p*DW +: DW]));
	endtask

	function automatic lane_valid_t random_mask();
		return lane_valid_t'($random(seed));
	endfunction

	task automatic add_cfg(input int port, input int src, input logic on,
		input port_mode_t mode, input int len);
		row_t row;
		row        = '0;
		row.is_cfg = 1'b1;
		row.port   = port;
		row.src    = lane_idx_t'(src);
		row.on     = on;
		row.mode   = mode;
		row.len    = acc_len_t'(len);
		rows.push_back(row);
	endtask

	task automatic add_beat(input logic run, input lane_valid_t valid);
		row_t row;
		row       = '0;
		row.run   = run;
		row.valid = valid;
		for (int w = 0; w < $bits(lane_bus_t) / 32; w++)
			row.data[w*32 +: 32] = $random(seed);
		rows.push_back(row);
	endtask

	task automatic build_rows();
		for (int i = 0; i < 4; i++)
			add_beat(1'b1, 8'hff);             // no route programmed yet
		for (int k = 0; k < 8; k++)
		begin
			add_cfg(0, k, 1'b1, MODE_PASS, 0);
			add_cfg(1, 7 - k, 1'b1, MODE_PASS, 0);
			add_beat(1'b1, 8'hff);
			add_beat(1'b1, random_mask());
		end
		add_beat(1'b1, 8'h7e);                 // lanes 7 and 0 invalid
		add_beat(1'b0, 8'hff);
		add_cfg(1, 3, 1'b0, MODE_PASS, 0);     // port 1 off
		add_beat(1'b1, 8'hff);
		add_cfg(0, 2, 1'b1, MODE_ACCUM, 1);
		add_cfg(1, 5, 1'b1, MODE_ACCUM, 3);
		for (int i = 0; i < 12; i++)
			add_beat(1'b1, random_mask());
		add_cfg(0, 2, 1'b1, MODE_ACCUM, 15);
		for (int i = 0; i < 40; i++)
			add_beat(1'b1, (i % 2) ? random_mask() : 8'hff);
		// port 0 restarted mid-sum, port 1 keeps summing
		add_cfg(0, 1, 1'b1, MODE_ACCUM, 15);
		for (int i = 0; i < 6; i++)
			add_beat(1'b1, 8'hff);
		add_cfg(0, 6, 1'b1, MODE_ACCUM, 3);
		for (int i = 0; i < 9; i++)
			add_beat(1'b1, 8'hff);
	endtask

	// reference model, walks the table once and fills in expected outputs
	task automatic predict_outputs();
		logic       on   [NP];
		lane_idx_t  src  [NP];
		port_mode_t mode [NP];
		int         len  [NP];
		lane_data_t sum  [NP];
		int         cnt  [NP];
		row_t       row;
		logic       v;
		lane_data_t d;
		int         q;
		for (int p = 0; p < NP; p++)
		begin
			on[p]   = 1'b0;
			mode[p] = MODE_PASS;
			sum[p]  = '0;
			cnt[p]  = 0;
		end
		for (int r = 0; r < rows.size(); r++)
		begin
			row           = rows[r];
			row.exp_valid = '0;
			row.exp_data  = '0;
			if (row.is_cfg)
			begin
				q       = int'(row.port);
				on[q]   = row.on;
				src[q]  = row.src;
				mode[q] = row.mode;
				len[q]  = (row.len == 0) ? 1 : int'(row.len);
				sum[q]  = '0;                  // write drops the partial sum
				cnt[q]  = 0;
			end
			else
			begin
				for (int p = 0; p < NP; p++)
				begin
					v = row.run && on[p] && row.valid[src[p]];
					d = v ? row.data[int'(src[p])*DW +: DW] : '0;
					if (mode[p] == MODE_PASS)
					begin
						row.exp_valid[p]         = v;
						row.exp_data[p*DW +: DW] = d;
					end
					else if (v)
					begin
						sum[p] = sum[p] + d;   // wraps at 16 bits
						cnt[p] = cnt[p] + 1;
						if (cnt[p] == len[p])
						begin
							row.exp_valid[p]         = 1'b1;
							row.exp_data[p*DW +: DW] = sum[p];
							sum[p]                   = '0;
							cnt[p]                   = 0;
						end
					end
				end
			end
			rows[r] = row;
		end
	endtask

	task automatic drive_row(input row_t row);
		i_cfg_we     = row.is_cfg;
		i_cfg_port   = row.port;
		i_cfg_src    = row.src;
		i_cfg_on     = row.on;
		i_cfg_mode   = row.mode;
		i_cfg_len    = row.len;
		i_run        = row.run;
		i_lane_valid = row.valid;
		i_lane_data  = row.data;
	endtask

	initial
	begin
		int wait_cnt;
		seed    = 32'h3452;
		i_reset = 1'b1;
		drive_row('0);
		build_rows();
		predict_outputs();
		pend_q.push_back('0);
		pend_q.push_back('0);

		wait_cnt = 0;
		while (i_reset)
		begin
			@(posedge CLK);
			wait_cnt++;
			if (wait_cnt > RESET_TIMEOUT)
			begin
				$display("reset was not released within %0d cycles", RESET_TIMEOUT);
				stop_with_failure();
			end
		end

		@(negedge CLK);
		for (int r = 0; r < rows.size(); r++)
		begin
			check_outputs(pend_q.pop_front());
			drive_row(rows[r]);
			pend_q.push_back(rows[r]);
			@(negedge CLK);
		end

		drive_row('0);
		wait_cnt = 0;
		while (pend_q.size() > 0)
		begin
			check_outputs(pend_q.pop_front());
			@(negedge CLK);
			wait_cnt++;
			if (wait_cnt > DRAIN_TIMEOUT)
			begin
				$display("expected outputs still pending after %0d cycles", DRAIN_TIMEOUT);
				stop_with_failure();
			end
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/fabric_types_pkg.sv
verilog/fabric_cmd_pkg.sv
verilog/route_ctrl.sv
verilog/mux_tree_8_1_seq.sv
verilog/port_accum.sv
verilog/lane_collector_top.sv
dv/lane_collector_tb.sv

//--- Bender.yml
package:
  name: lane_collector

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fabric_types_pkg.sv
      - verilog/fabric_cmd_pkg.sv
      - verilog/route_ctrl.sv
      - verilog/mux_tree_8_1_seq.sv
      - verilog/port_accum.sv
      - verilog/lane_collector_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/lane_collector_tb.sv
